// ==== sim.f ====
+incdir+design
+incdir+dv
design/rv64_isa_pkg.sv
design/decode_pkg.sv
design/ctrl_decoder.sv
design/imm_extractor.sv
design/decode_handshake.sv
design/instr_decoder.sv
dv/tb_instr_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
  --top-module tb_instr_decoder --Mdir obj_dir -o tb_instr_decoder > build.log 2>&1 \
  && ./obj_dir/tb_instr_decoder > sim.log 2>&1 \
  && grep -qF '** PASS **' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== dv/decode_vectors.svh ====
// Decode vectors; encodings use x1, x2 and x3 as rd, rs1 and rs2 throughout
// Each row gives instr, {exc_not_instr, exc_code}, fu_op, pipes {int mul long ctl mem sys},
// flags {irf_w late_iwb opw src2_imm dcache_r dcache_w mem src1_pc baddr_rs1},
// {illegal access page itlb icache}, imm

task automatic load_vectors();
  // ADD, SUBW, SLTIU -1, ADDIW 5, LUI, AUIPC
  add_vector(32'h003100b3, 3'b000, e_int_op_add, 6'b100000, 9'b100000000, 5'h00, 64'd0);
  add_vector(32'h403100bb, 3'b000, e_int_op_sub, 6'b100000, 9'b101000000, 5'h00, 64'd0);
  add_vector(32'hfff13093, 3'b000, e_int_op_sltu, 6'b100000, 9'b100100000, 5'h00, -64'd1);
  add_vector(32'h0051009b, 3'b000, e_int_op_add, 6'b100000, 9'b101100000, 5'h00, 64'd5);
  add_vector(32'h800000b7, 3'b000, e_int_op_pass_src2, 6'b100000, 9'b100100000, 5'h00,
             -64'h80000000);
  add_vector(32'h12345097, 3'b000, e_int_op_add, 6'b100000, 9'b100100010, 5'h00,
             64'h12345000);
  // MUL, DIVUW, REM
  add_vector(32'h023100b3, 3'b000, e_mul_op_imul, 6'b010000, 9'b100000000, 5'h00, 64'd0);
  add_vector(32'h023150bb, 3'b000, e_mul_op_divu, 6'b001000, 9'b011000000, 5'h00, 64'd0);
  add_vector(32'h023160b3, 3'b000, e_mul_op_rem, 6'b001000, 9'b010000000, 5'h00, 64'd0);
  // JAL -8, JALR 16, BEQ -16, BGEU 8, LD -8, LBU 3, SW -4, SD 24
  add_vector(32'hff9ff0ef, 3'b000, e_ctrl_op_jal, 6'b000100, 9'b100000000, 5'h00, -64'd8);
  add_vector(32'h010100e7, 3'b000, e_ctrl_op_jalr, 6'b000100, 9'b100000001, 5'h00, 64'd16);
  add_vector(32'hfe3108e3, 3'b000, e_ctrl_op_beq, 6'b000100, 9'b000000000, 5'h00, -64'd16);
  add_vector(32'h00317463, 3'b000, e_ctrl_op_bgeu, 6'b000100, 9'b000000000, 5'h00, 64'd8);
  add_vector(32'hff813083, 3'b000, e_dcache_op_ld, 6'b000010, 9'b100010100, 5'h00, -64'd8);
  add_vector(32'h00314083, 3'b000, e_dcache_op_lbu, 6'b000010, 9'b100010100, 5'h00, 64'd3);
  add_vector(32'hfe312e23, 3'b000, e_dcache_op_sw, 6'b000010, 9'b000001100, 5'h00, -64'd4);
  add_vector(32'h00313c23, 3'b000, e_dcache_op_sd, 6'b000010, 9'b000001100, 5'h00, 64'd24);
  // Bad OP funct7, OP-32 XOR, ECALL, FENCE, FADD.S
  add_vector(32'h403110b3, 3'b000, e_int_op_add, 6'b000001, 9'b000000000, 5'h10, 64'd0);
  add_vector(32'h003140bb, 3'b000, e_int_op_add, 6'b000001, 9'b000000000, 5'h10, 64'd0);
  add_vector(32'h00000073, 3'b000, e_int_op_add, 6'b000001, 9'b000000000, 5'h10, 64'd0);
  add_vector(32'h0ff0000f, 3'b000, e_int_op_add, 6'b000001, 9'b000000000, 5'h10, 64'd0);
  add_vector(32'h003100d3, 3'b000, e_int_op_add, 6'b000001, 9'b000000000, 5'h10, 64'd0);
  // Front-end faults where the immediate still follows the opcode bits
  add_vector(32'h003100b3, 3'b100, e_int_op_add, 6'b000001, 9'b000000000, 5'h08, 64'd0);
  add_vector(32'hffffffff, 3'b101, e_int_op_add, 6'b000001, 9'b000000000, 5'h04, 64'd0);
  add_vector(32'h800000b7, 3'b110, e_int_op_add, 6'b000001, 9'b000000000, 5'h02,
             -64'h80000000);
  add_vector(32'h00000073, 3'b111, e_int_op_add, 6'b000001, 9'b000000000, 5'h01, 64'd0);
endtask

// ==== dv/tb_instr_decoder.sv ====
// Self-checking testbench for instr_decoder; needs Verilator with --timing and --assert
`include "decode_defines.svh"

module tb_instr_decoder
  import decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES   = 4;
  localparam int ACK_WAIT_LIMIT = 4;

  typedef struct packed {
    logic [`INSTR_WIDTH-1:0] instr;
    logic [2:0]              exc;
    fu_op_e                  fu_op;
    logic [5:0]              pipes;
    logic [8:0]              flags;
    logic [4:0]              status;
    logic [`DWORD_WIDTH-1:0] imm;
  } vector_s;

  logic                    clk;
  logic                    reset;
  logic                    req;
  decode_req_s             req_data;
  logic                    ack;
  decode_s                 decode;
  logic [`DWORD_WIDTH-1:0] imm;

  vector_s vectors[$];
  int      value_errors;
  int      protocol_errors;

  instr_decoder UUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .decode_o   (decode),
    .imm_o      (imm)
  );

  task automatic add_vector(input logic [`INSTR_WIDTH-1:0] instr, input logic [2:0] exc,
                            input fu_op_e fu_op, input logic [5:0] pipes,
                            input logic [8:0] flags, input logic [4:0] status,
                            input logic [`DWORD_WIDTH-1:0] imm);
    vector_s v;
    v = '{instr, exc, fu_op, pipes, flags, status, imm};
    vectors.push_back(v);
  endtask

  `include "decode_vectors.svh"

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // Observed fields gathered in the same bit order as the table
  task automatic check_outputs(input vector_s v);
    logic [5:0] pipes;
    logic [8:0] flags;
    logic [4:0] status;
    pipes  = {decode.pipe_int_v, decode.pipe_mul_v, decode.pipe_long_v,
              decode.pipe_ctl_v, decode.pipe_mem_v, decode.pipe_sys_v};
    flags  = {decode.irf_w_v, decode.late_iwb_v, decode.opw_v,
              decode.src2_sel == e_src2_is_imm, decode.dcache_r_v, decode.dcache_w_v,
              decode.mem_v, decode.src1_sel == e_src1_is_pc,
              decode.baddr_sel == e_baddr_is_rs1};
    status = {decode.illegal_instr, decode.instr_access_fault, decode.instr_page_fault,
              decode.itlb_miss, decode.icache_miss};
    check_value("decode_o.fu_op", 64'(v.fu_op), 64'(decode.fu_op));
    check_value("decode_o pipe valids", 64'(v.pipes), 64'(pipes));
    check_value("decode_o flags", 64'(v.flags), 64'(flags));
    check_value("decode_o illegal and faults", 64'(v.status), 64'(status));
    check_value("imm_o", v.imm, imm);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    int      idx;
    int      wait_cycles;
    vector_s v;
    req             = 1'b0;
    req_data        = '0;
    reset           = 1'b1;
    value_errors    = 0;
    protocol_errors = 0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("ack_o", 64'(1'b0), 64'(ack));
    check_value("decode_o", 64'd0, 64'(decode));
    check_value("imm_o", 64'd0, imm);

    for (idx = 0; idx < vectors.size(); idx++)
    begin
      v                      = vectors[idx];
      req_data.instr         = v.instr;
      req_data.exc_not_instr = v.exc[2];
      req_data.exc_code      = fe_exc_e'(v.exc[1:0]);
      req                    = 1'b1;
      wait_cycles            = 0;
      while (ack !== 1'b1 && wait_cycles < ACK_WAIT_LIMIT)
      begin
        @(negedge clk);
        wait_cycles++;
      end
      assert (wait_cycles == 1)
      else
      begin
        $display("Vector %0d: ack_o rose after %0d cycles instead of 1", idx, wait_cycles);
        protocol_errors++;
      end
      check_outputs(v);

      // Requester stalls the stage for a few cycles
      repeat (idx % 4) @(negedge clk);
      check_value("ack_o", 64'(1'b1), 64'(ack));
      check_outputs(v);

      req            = 1'b0;
      req_data.instr = ~v.instr;
      wait_cycles    = 0;
      while (ack !== 1'b0 && wait_cycles < ACK_WAIT_LIMIT)
      begin
        @(negedge clk);
        wait_cycles++;
      end
      assert (wait_cycles == 1)
      else
      begin
        $display("Vector %0d: ack_o fell after %0d cycles instead of 1", idx, wait_cycles);
        protocol_errors++;
      end
      // Results must outlive the handshake
      check_outputs(v);
    end

    $display("Summary: %0d vectors, %0d value errors, %0d protocol errors",
             vectors.size(), value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    int cycle_count;
    int timeout_cycles;
    cycle_count = 0;
    @(posedge clk);
    timeout_cycles = vectors.size() * 8 + 50;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Summary: %0d vectors, %0d value errors, %0d protocol errors",
             vectors.size(), value_errors, protocol_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== design/instr_decoder.sv ====
// Registered decode stage; ack_o rises one clock after req_i is first sampled high
`include "decode_defines.svh"

module instr_decoder
  import decode_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  decode_req_s             req_data_i,
  output logic                    ack_o,
  output decode_s                 decode_o,
  output logic [`DWORD_WIDTH-1:0] imm_o
);

  decode_s                 decode_comb;
  logic [`DWORD_WIDTH-1:0] imm_comb;

  ctrl_decoder u_ctrl_decoder (
    .req_i    (req_data_i),
    .decode_o (decode_comb)
  );

  // Same instruction word, read through its immediate fields
  imm_extractor u_imm_extractor (
    .instr_i (req_data_i.instr),
    .imm_o   (imm_comb)
  );

  decode_handshake u_decode_handshake (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .decode_i (decode_comb),
    .imm_i    (imm_comb),
    .ack_o    (ack_o),
    .decode_o (decode_o),
    .imm_o    (imm_o)
  );

endmodule

// ==== design/decode_handshake.sv ====
// Four-phase req/ack with one transfer at a time; requester must hold its data while req_i is high
`include "decode_defines.svh"

module decode_handshake
  import decode_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  decode_s                 decode_i,
  input  logic [`DWORD_WIDTH-1:0] imm_i,
  output logic                    ack_o,
  output decode_s                 decode_o,
  output logic [`DWORD_WIDTH-1:0] imm_o
);

  logic                    ack_q;
  logic                    accept;
  logic                    release_ack;
  decode_s                 decode_q;
  logic [`DWORD_WIDTH-1:0] imm_q;

  // New request only once the previous ack has dropped
  assign accept      = req_i & ~ack_q;
  assign release_ack = ~req_i & ack_q;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      ack_q    <= 1'b0;
      decode_q <= '0;
      imm_q    <= '0;
    end
    else if (accept)
    begin
      ack_q    <= 1'b1;
      decode_q <= decode_i;
      imm_q    <= imm_i;
    end
    else if (release_ack)
      ack_q <= 1'b0;
  end

  // Results hold until the next accepted request
  assign ack_o    = ack_q;
  assign decode_o = decode_q;
  assign imm_o    = imm_q;

endmodule

// ==== design/imm_extractor.sv ====
// Combinational; opcodes without an immediate, including every illegal one, give zero
`include "decode_defines.svh"

module imm_extractor
  import rv64_isa_pkg::*;
(
  input  rv64_instr_u             instr_i,
  output logic [`DWORD_WIDTH-1:0] imm_o
);

  always_comb
  begin
    case (instr_i.r.opcode)
      e_op_lui, e_op_auipc:
        imm_o = {{(`DWORD_WIDTH-32){instr_i.u.imm31_12[19]}}, instr_i.u.imm31_12, 12'b0};
      e_op_jal:
        imm_o = {{(`DWORD_WIDTH-20){instr_i.j.imm20}},
                 instr_i.j.imm19_12,
                 instr_i.j.imm11,
                 instr_i.j.imm10_1,
                 1'b0};
      e_op_branch:
        imm_o = {{(`DWORD_WIDTH-12){instr_i.b.imm12}},
                 instr_i.b.imm11,
                 instr_i.b.imm10_5,
                 instr_i.b.imm4_1,
                 1'b0};
      e_op_store:
        imm_o = {{(`DWORD_WIDTH-12){instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
      // Shift amounts ride in the low I bits
      e_op_jalr, e_op_load, e_op_imm, e_op_imm_32:
        imm_o = {{(`DWORD_WIDTH-12){instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
      default:
        imm_o = '0;
    endcase
  end

endmodule

// ==== design/ctrl_decoder.sv ====
// Combinational; only RV64I integer, M, load and store decode, everything else traps as illegal
module ctrl_decoder
  import rv64_isa_pkg::*;
  import decode_pkg::*;
(
  input  decode_req_s req_i,
  output decode_s     decode_o
);

  rv64_instr_u instr;
  decode_s     decode;
  logic        illegal;
  logic [6:0]  shift_f7;

  assign instr.raw = req_i.instr;

  // RV64 OP-IMM shifts have a 6-bit shamt, so bit 25 is not part of funct7
  assign shift_f7 = (instr.r.opcode == e_op_imm_32) ? instr.r.funct7
                                                    : {instr.r.funct7[6:1], 1'b0};

  always_comb
  begin
    decode  = '0;
    illegal = 1'b0;

    case (instr.r.opcode)
      e_op_op, e_op_32:
      begin
        decode.opw_v = (instr.r.opcode == e_op_32);
        case ({instr.r.funct7, instr.r.funct3})
          {F7_BASE, 3'b000}:   decode.fu_op = e_int_op_add;
          {F7_ALT, 3'b000}:    decode.fu_op = e_int_op_sub;
          {F7_BASE, 3'b001}:   decode.fu_op = e_int_op_sll;
          {F7_BASE, 3'b010}:   decode.fu_op = e_int_op_slt;
          {F7_BASE, 3'b011}:   decode.fu_op = e_int_op_sltu;
          {F7_BASE, 3'b100}:   decode.fu_op = e_int_op_xor;
          {F7_BASE, 3'b101}:   decode.fu_op = e_int_op_srl;
          {F7_ALT, 3'b101}:    decode.fu_op = e_int_op_sra;
          {F7_BASE, 3'b110}:   decode.fu_op = e_int_op_or;
          {F7_BASE, 3'b111}:   decode.fu_op = e_int_op_and;
          {F7_MULDIV, 3'b000}: decode.fu_op = e_mul_op_imul;
          {F7_MULDIV, 3'b100}: decode.fu_op = e_mul_op_div;
          {F7_MULDIV, 3'b101}: decode.fu_op = e_mul_op_divu;
          {F7_MULDIV, 3'b110}: decode.fu_op = e_mul_op_rem;
          {F7_MULDIV, 3'b111}: decode.fu_op = e_mul_op_remu;
          default:             illegal = 1'b1;
        endcase

        if (decode.fu_op == e_mul_op_imul)
          decode.pipe_mul_v = 1'b1;
        else if (decode.fu_op inside {e_mul_op_div, e_mul_op_divu, e_mul_op_rem, e_mul_op_remu})
        begin
          decode.pipe_long_v = 1'b1;
          decode.late_iwb_v  = 1'b1;
        end
        else
          decode.pipe_int_v = 1'b1;
        decode.irf_w_v = ~decode.late_iwb_v;
      end
      e_op_imm, e_op_imm_32:
      begin
        decode.pipe_int_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.opw_v      = (instr.i.opcode == e_op_imm_32);
        decode.src2_sel   = e_src2_is_imm;
        case (instr.i.funct3)
          3'b000: decode.fu_op = e_int_op_add;
          3'b010: decode.fu_op = e_int_op_slt;
          3'b011: decode.fu_op = e_int_op_sltu;
          3'b100: decode.fu_op = e_int_op_xor;
          3'b110: decode.fu_op = e_int_op_or;
          3'b111: decode.fu_op = e_int_op_and;
          3'b001:
          begin
            decode.fu_op = e_int_op_sll;
            illegal      = (shift_f7 != F7_BASE);
          end
          default:
          begin
            decode.fu_op = (shift_f7 == F7_ALT) ? e_int_op_sra : e_int_op_srl;
            illegal      = !(shift_f7 inside {F7_BASE, F7_ALT});
          end
        endcase
      end
      e_op_lui:
      begin
        decode.pipe_int_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.fu_op      = e_int_op_pass_src2;
        decode.src2_sel   = e_src2_is_imm;
      end
      e_op_auipc:
      begin
        decode.pipe_int_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.fu_op      = e_int_op_add;
        decode.src1_sel   = e_src1_is_pc;
        decode.src2_sel   = e_src2_is_imm;
      end
      e_op_jal:
      begin
        decode.pipe_ctl_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.fu_op      = e_ctrl_op_jal;
        decode.baddr_sel  = e_baddr_is_pc;
      end
      e_op_jalr:
      begin
        decode.pipe_ctl_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.fu_op      = e_ctrl_op_jalr;
        decode.baddr_sel  = e_baddr_is_rs1;
        illegal           = (instr.i.funct3 != 3'b000);
      end
      e_op_branch:
      begin
        decode.pipe_ctl_v = 1'b1;
        decode.baddr_sel  = e_baddr_is_pc;
        case (instr.b.funct3)
          3'b000:  decode.fu_op = e_ctrl_op_beq;
          3'b001:  decode.fu_op = e_ctrl_op_bne;
          3'b100:  decode.fu_op = e_ctrl_op_blt;
          3'b101:  decode.fu_op = e_ctrl_op_bge;
          3'b110:  decode.fu_op = e_ctrl_op_bltu;
          3'b111:  decode.fu_op = e_ctrl_op_bgeu;
          default: illegal = 1'b1;
        endcase
      end
      e_op_load:
      begin
        decode.pipe_mem_v = 1'b1;
        decode.irf_w_v    = 1'b1;
        decode.dcache_r_v = 1'b1;
        decode.mem_v      = 1'b1;
        case (instr.i.funct3)
          3'b000:  decode.fu_op = e_dcache_op_lb;
          3'b001:  decode.fu_op = e_dcache_op_lh;
          3'b010:  decode.fu_op = e_dcache_op_lw;
          3'b011:  decode.fu_op = e_dcache_op_ld;
          3'b100:  decode.fu_op = e_dcache_op_lbu;
          3'b101:  decode.fu_op = e_dcache_op_lhu;
          3'b110:  decode.fu_op = e_dcache_op_lwu;
          default: illegal = 1'b1;
        endcase
      end
      e_op_store:
      begin
        decode.pipe_mem_v = 1'b1;
        decode.dcache_w_v = 1'b1;
        decode.mem_v      = 1'b1;
        case (instr.s.funct3)
          3'b000:  decode.fu_op = e_dcache_op_sb;
          3'b001:  decode.fu_op = e_dcache_op_sh;
          3'b010:  decode.fu_op = e_dcache_op_sw;
          3'b011:  decode.fu_op = e_dcache_op_sd;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Word forms exist only for add, sub, shifts and M ops
    if (decode.opw_v && !(decode.fu_op inside {e_int_op_add, e_int_op_sub, e_int_op_sll,
        e_int_op_srl, e_int_op_sra, e_mul_op_imul, e_mul_op_div, e_mul_op_divu,
        e_mul_op_rem, e_mul_op_remu}))
      illegal = 1'b1;

    // Front-end faults win over anything decoded from the bits
    if (req_i.exc_not_instr)
    begin
      decode            = '0;
      decode.pipe_sys_v = 1'b1;
      case (req_i.exc_code)
        e_instr_access_fault: decode.instr_access_fault = 1'b1;
        e_instr_page_fault:   decode.instr_page_fault   = 1'b1;
        e_itlb_miss:          decode.itlb_miss          = 1'b1;
        default:              decode.icache_miss        = 1'b1;
      endcase
    end
    else if (illegal)
    begin
      decode               = '0;
      decode.pipe_sys_v    = 1'b1;
      decode.illegal_instr = 1'b1;
    end
  end

  assign decode_o = decode;

endmodule

// ==== design/decode_pkg.sv ====
// Control word for a single-issue backend; no FP, atomic, fence or CSR fields exist
`include "decode_defines.svh"

package decode_pkg;

  typedef enum logic [`FU_OP_WIDTH-1:0] {
    e_int_op_add, e_int_op_sub, e_int_op_sll, e_int_op_srl, e_int_op_sra,
    e_int_op_slt, e_int_op_sltu, e_int_op_xor, e_int_op_or, e_int_op_and,
    e_int_op_pass_src2,
    e_mul_op_imul, e_mul_op_div, e_mul_op_divu, e_mul_op_rem, e_mul_op_remu,
    e_ctrl_op_jal, e_ctrl_op_jalr, e_ctrl_op_beq, e_ctrl_op_bne,
    e_ctrl_op_blt, e_ctrl_op_bge, e_ctrl_op_bltu, e_ctrl_op_bgeu,
    e_dcache_op_lb, e_dcache_op_lh, e_dcache_op_lw, e_dcache_op_ld,
    e_dcache_op_lbu, e_dcache_op_lhu, e_dcache_op_lwu,
    e_dcache_op_sb, e_dcache_op_sh, e_dcache_op_sw, e_dcache_op_sd
  } fu_op_e;

  typedef enum logic {e_src1_is_rs1, e_src1_is_pc} src1_sel_e;
  typedef enum logic {e_src2_is_rs2, e_src2_is_imm} src2_sel_e;
  typedef enum logic {e_baddr_is_pc, e_baddr_is_rs1} baddr_sel_e;

  typedef enum logic [`EXC_CODE_WIDTH-1:0] {
    e_instr_access_fault,
    e_instr_page_fault,
    e_itlb_miss,
    e_icache_miss
  } fe_exc_e;

  typedef struct packed {
    logic       pipe_int_v;
    logic       pipe_mul_v;
    logic       pipe_long_v;
    logic       pipe_ctl_v;
    logic       pipe_mem_v;
    logic       pipe_sys_v;
    logic       irf_w_v;
    // Writeback arrives out of band from the long pipe
    logic       late_iwb_v;
    logic       opw_v;
    logic       dcache_r_v;
    logic       dcache_w_v;
    logic       mem_v;
    src1_sel_e  src1_sel;
    src2_sel_e  src2_sel;
    baddr_sel_e baddr_sel;
    fu_op_e     fu_op;
    logic       illegal_instr;
    logic       instr_access_fault;
    logic       instr_page_fault;
    logic       itlb_miss;
    logic       icache_miss;
  } decode_s;

  typedef struct packed {
    logic [`INSTR_WIDTH-1:0] instr;
    logic                    exc_not_instr;
    fe_exc_e                 exc_code;
  } decode_req_s;

endpackage

// ==== design/rv64_isa_pkg.sv ====
// RV64 base encodings only; opcodes outside the integer, M, load and store subset are absent
`include "decode_defines.svh"

package rv64_isa_pkg;

  typedef enum logic [6:0] {
    e_op_load   = 7'b0000011,
    e_op_imm    = 7'b0010011,
    e_op_auipc  = 7'b0010111,
    e_op_imm_32 = 7'b0011011,
    e_op_store  = 7'b0100011,
    e_op_op     = 7'b0110011,
    e_op_lui    = 7'b0110111,
    e_op_32     = 7'b0111011,
    e_op_branch = 7'b1100011,
    e_op_jalr   = 7'b1100111,
    e_op_jal    = 7'b1101111
  } rv64_opcode_e;

  // funct7 groups for OP and OP-32
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef struct packed {
    logic [6:0]   funct7;
    logic [4:0]   rs2;
    logic [4:0]   rs1;
    logic [2:0]   funct3;
    logic [4:0]   rd;
    rv64_opcode_e opcode;
  } rv64_rtype_s;

  typedef struct packed {
    logic [11:0]  imm11_0;
    logic [4:0]   rs1;
    logic [2:0]   funct3;
    logic [4:0]   rd;
    rv64_opcode_e opcode;
  } rv64_itype_s;

  typedef struct packed {
    logic [6:0]   imm11_5;
    logic [4:0]   rs2;
    logic [4:0]   rs1;
    logic [2:0]   funct3;
    logic [4:0]   imm4_0;
    rv64_opcode_e opcode;
  } rv64_stype_s;

  // B and J scramble the offset bits across the word
  typedef struct packed {
    logic         imm12;
    logic [5:0]   imm10_5;
    logic [4:0]   rs2;
    logic [4:0]   rs1;
    logic [2:0]   funct3;
    logic [3:0]   imm4_1;
    logic         imm11;
    rv64_opcode_e opcode;
  } rv64_btype_s;

  typedef struct packed {
    logic [19:0]  imm31_12;
    logic [4:0]   rd;
    rv64_opcode_e opcode;
  } rv64_utype_s;

  typedef struct packed {
    logic         imm20;
    logic [9:0]   imm10_1;
    logic         imm11;
    logic [7:0]   imm19_12;
    logic [4:0]   rd;
    rv64_opcode_e opcode;
  } rv64_jtype_s;

  typedef union packed {
    logic [`INSTR_WIDTH-1:0] raw;
    rv64_rtype_s             r;
    rv64_itype_s             i;
    rv64_stype_s             s;
    rv64_btype_s             b;
    rv64_utype_s             u;
    rv64_jtype_s             j;
  } rv64_instr_u;

endpackage

// ==== design/decode_defines.svh ====
// Widths shared by the decode packages and RTL; the decoder only supports a 32-bit encoding
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Base instruction word without compressed forms
`define INSTR_WIDTH 32

// Immediate and integer datapath width
`define DWORD_WIDTH 64

// Enough for every functional-unit operation
`define FU_OP_WIDTH 6

// Front-end exception code
`define EXC_CODE_WIDTH 2

`endif
